/* build.f */
+incdir+include
hw/ni_pkg.sv
hw/ni_flit_if.sv
hw/ni_axi_intake.sv
hw/ni_req_packer.sv
hw/ni_rsp_unpacker.sv
hw/ni_chimney.sv
tb/ni_chimney_asserts.sv
tb/tb_ni_chimney.sv

/* hw/ni_axi_intake.sv */
// NI intake that maps AXI requests to destination nodes and builds flit headers
`timescale 1ns/1ps
`include "ni_config.svh"

module ni_axi_intake (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  ni_pkg::node_id_t node_id_i,
  // AXI write address
  input  logic             aw_valid_i,
  output logic             aw_ready_o,
  input  ni_pkg::addr_t    aw_addr_i,
  input  ni_pkg::axi_id_t  aw_id_i,
  input  ni_pkg::len_t     aw_len_i,
  // AXI write data
  input  logic             w_valid_i,
  output logic             w_ready_o,
  input  ni_pkg::data_t    w_data_i,
  input  ni_pkg::strb_t    w_strb_i,
  input  logic             w_last_i,
  // AXI read address
  input  logic             ar_valid_i,
  output logic             ar_ready_o,
  input  ni_pkg::addr_t    ar_addr_i,
  input  ni_pkg::axi_id_t  ar_id_i,
  input  ni_pkg::len_t     ar_len_i,
  // Flit links towards the packer
  ni_flit_if.sender        aw_link,
  ni_flit_if.sender        w_link,
  ni_flit_if.sender        ar_link
);

  localparam int unsigned NUM_RULES = `NI_NUM_RULES;

  localparam ni_pkg::addr_t [NUM_RULES-1:0] RULE_BASE =
    {`NI_RULE_BASE_3, `NI_RULE_BASE_2, `NI_RULE_BASE_1, `NI_RULE_BASE_0};
  localparam ni_pkg::addr_t [NUM_RULES-1:0] RULE_END =
    {`NI_RULE_END_3, `NI_RULE_END_2, `NI_RULE_END_1, `NI_RULE_END_0};
  localparam ni_pkg::node_id_t [NUM_RULES-1:0] RULE_NODE =
    {`NI_RULE_NODE_3, `NI_RULE_NODE_2, `NI_RULE_NODE_1, `NI_RULE_NODE_0};

  ni_pkg::node_id_t     aw_dst;
  ni_pkg::node_id_t     ar_dst;
  ni_pkg::node_id_t     w_dst_q;
  ni_pkg::req_payload_t aw_pl;
  ni_pkg::req_payload_t w_pl;
  ni_pkg::req_payload_t ar_pl;

  // First matching rule wins
  function automatic ni_pkg::node_id_t lookup_node(input ni_pkg::addr_t addr);
    ni_pkg::node_id_t node;
    logic             hit;
    node = `NI_DEFAULT_NODE;
    hit  = 1'b0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (!hit && addr >= RULE_BASE[i] && addr < RULE_END[i]) begin
        node = RULE_NODE[i];
        hit  = 1'b1;
      end
    end
    return node;
  endfunction

  assign aw_dst = lookup_node(aw_addr_i);
  assign ar_dst = lookup_node(ar_addr_i);

  always_comb begin
    aw_pl         = '0;
    aw_pl.ax.addr = aw_addr_i;
    aw_pl.ax.id   = aw_id_i;
    aw_pl.ax.len  = aw_len_i;
    w_pl          = '0;
    w_pl.w.data   = w_data_i;
    w_pl.w.strb   = w_strb_i;
    w_pl.w.last   = w_last_i;
    ar_pl         = '0;
    ar_pl.ax.addr = ar_addr_i;
    ar_pl.ax.id   = ar_id_i;
    ar_pl.ax.len  = ar_len_i;
  end

  ////////////////////////////////////////
  // Link drive
  ////////////////////////////////////////

  // AW opens the write packet, so it never closes it
  assign aw_link.valid   = aw_valid_i;
  assign aw_link.hdr     = '{dst_id: aw_dst, src_id: node_id_i, ch: ni_pkg::CH_AW, last: 1'b0};
  assign aw_link.payload = aw_pl;
  assign aw_ready_o      = aw_link.ready;

  assign w_link.valid    = w_valid_i;
  assign w_link.hdr      = '{dst_id: w_dst_q, src_id: node_id_i, ch: ni_pkg::CH_W,
                             last: w_last_i};
  assign w_link.payload  = w_pl;
  assign w_ready_o       = w_link.ready;

  assign ar_link.valid   = ar_valid_i;
  assign ar_link.hdr     = '{dst_id: ar_dst, src_id: node_id_i, ch: ni_pkg::CH_AR, last: 1'b1};
  assign ar_link.payload = ar_pl;
  assign ar_ready_o      = ar_link.ready;

  // W beats carry no address, they follow the last accepted AW
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_dst_q <= `NI_DEFAULT_NODE;
    end else if (aw_valid_i && aw_link.ready) begin
      w_dst_q <= aw_dst;
    end
  end

endmodule

/* hw/ni_chimney.sv */
// NI chimney top joining AXI manager ports to the request and response links
`timescale 1ns/1ps

module ni_chimney (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  ni_pkg::node_id_t  node_id_i,
  // AXI write address
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  ni_pkg::addr_t     aw_addr_i,
  input  ni_pkg::axi_id_t   aw_id_i,
  input  ni_pkg::len_t      aw_len_i,
  // AXI write data
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  ni_pkg::data_t     w_data_i,
  input  ni_pkg::strb_t     w_strb_i,
  input  logic              w_last_i,
  // AXI read address
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  ni_pkg::addr_t     ar_addr_i,
  input  ni_pkg::axi_id_t   ar_id_i,
  input  ni_pkg::len_t      ar_len_i,
  // AXI write response
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output ni_pkg::axi_id_t   b_id_o,
  output ni_pkg::resp_t     b_resp_o,
  // AXI read data
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output ni_pkg::axi_id_t   r_id_o,
  output ni_pkg::data_t     r_data_o,
  output ni_pkg::resp_t     r_resp_o,
  output logic              r_last_o,
  // Request link to the network
  output logic              req_valid_o,
  input  logic              req_ready_i,
  output ni_pkg::req_flit_t req_flit_o,
  // Response link from the network
  input  logic              rsp_valid_i,
  output logic              rsp_ready_o,
  input  ni_pkg::rsp_flit_t rsp_flit_i
);

  ni_flit_if #(.payload_t(ni_pkg::req_payload_t)) aw_link ();
  ni_flit_if #(.payload_t(ni_pkg::req_payload_t)) w_link ();
  ni_flit_if #(.payload_t(ni_pkg::req_payload_t)) ar_link ();
  ni_flit_if #(.payload_t(ni_pkg::rsp_payload_t)) rsp_link ();

  ////////////////////////////////////////
  // Request path
  ////////////////////////////////////////

  ni_axi_intake u_intake (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .node_id_i  (node_id_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .aw_id_i    (aw_id_i),
    .aw_len_i   (aw_len_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .ar_id_i    (ar_id_i),
    .ar_len_i   (ar_len_i),
    .aw_link    (aw_link.sender),
    .w_link     (w_link.sender),
    .ar_link    (ar_link.sender)
  );

  ni_req_packer u_packer (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .aw_link     (aw_link.receiver),
    .w_link      (w_link.receiver),
    .ar_link     (ar_link.receiver),
    .req_valid_o (req_valid_o),
    .req_ready_i (req_ready_i),
    .req_flit_o  (req_flit_o)
  );

  ////////////////////////////////////////
  // Response path
  ////////////////////////////////////////

  // Plain link ports onto the internal response link
  assign rsp_link.valid   = rsp_valid_i;
  assign rsp_link.hdr     = rsp_flit_i.hdr;
  assign rsp_link.payload = rsp_flit_i.payload;
  assign rsp_ready_o      = rsp_link.ready;

  ni_rsp_unpacker u_unpacker (
    .rsp_link  (rsp_link.receiver),
    .b_valid_o (b_valid_o),
    .b_ready_i (b_ready_i),
    .b_id_o    (b_id_o),
    .b_resp_o  (b_resp_o),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready_i),
    .r_id_o    (r_id_o),
    .r_data_o  (r_data_o),
    .r_resp_o  (r_resp_o),
    .r_last_o  (r_last_o)
  );

endmodule

/* hw/ni_flit_if.sv */
// NI flit link carrying a header and a typed payload under valid/ready
`timescale 1ns/1ps

interface ni_flit_if #(
  parameter type payload_t = logic
);

  logic              valid;
  logic              ready;
  ni_pkg::flit_hdr_t hdr;
  payload_t          payload;

  // Flit source, holds hdr and payload stable while valid waits for ready
  modport sender (
    output valid,
    output hdr,
    output payload,
    input  ready
  );

  // Flit sink
  modport receiver (
    input  valid,
    input  hdr,
    input  payload,
    output ready
  );

endinterface

/* hw/ni_pkg.sv */
// NI package with the channel encoding, flit header and payload types
`include "ni_config.svh"

package ni_pkg;

  ////////////////////////////////////////
  // AXI field types
  ////////////////////////////////////////

  typedef logic [`NI_ADDR_W-1:0]   addr_t;
  typedef logic [`NI_DATA_W-1:0]   data_t;
  typedef logic [`NI_STRB_W-1:0]   strb_t;
  typedef logic [`NI_AXI_ID_W-1:0] axi_id_t;
  typedef logic [`NI_LEN_W-1:0]    len_t;
  typedef logic [`NI_NODE_W-1:0]   node_id_t;

  // Response codes, only the two the NI uses get names
  typedef logic [1:0] resp_t;
  localparam resp_t OKAY   = 2'b00;
  localparam resp_t SLVERR = 2'b10;

  // Channel carried by a flit
  typedef enum logic [2:0] {
    CH_AW = 3'd0,
    CH_W  = 3'd1,
    CH_AR = 3'd2,
    CH_B  = 3'd3,
    CH_R  = 3'd4
  } axi_ch_e;

  ////////////////////////////////////////
  // Flit layout
  ////////////////////////////////////////

  typedef struct packed {
    node_id_t dst_id;
    node_id_t src_id;
    axi_ch_e  ch;
    logic     last;
  } flit_hdr_t;

  // AW and AR share one layout
  typedef struct packed {
    addr_t   addr;
    axi_id_t id;
    len_t    len;
  } ax_payload_t;

  localparam int unsigned AX_PL_W  = $bits(ax_payload_t);
  localparam int unsigned W_BEAT_W = `NI_DATA_W + `NI_STRB_W + 1;

  // W beat padded up to the AW/AR size
  typedef struct packed {
    data_t                        data;
    strb_t                        strb;
    logic                         last;
    logic [AX_PL_W-W_BEAT_W-1:0]  rsvd;
  } w_payload_t;

  typedef union packed {
    ax_payload_t ax;
    w_payload_t  w;
  } req_payload_t;

  typedef struct packed {
    axi_id_t id;
    resp_t   resp;
    data_t   data;
    logic    last;
  } rsp_payload_t;

  typedef struct packed {
    flit_hdr_t    hdr;
    req_payload_t payload;
  } req_flit_t;

  typedef struct packed {
    flit_hdr_t    hdr;
    rsp_payload_t payload;
  } rsp_flit_t;

endpackage

/* hw/ni_req_packer.sv */
// NI request packer arbitrating write packets against reads onto one link
`timescale 1ns/1ps

module ni_req_packer (
  input  logic              clk_i,
  input  logic              arst_n_i,
  ni_flit_if.receiver       aw_link,
  ni_flit_if.receiver       w_link,
  ni_flit_if.receiver       ar_link,
  output logic              req_valid_o,
  input  logic              req_ready_i,
  output ni_pkg::req_flit_t req_flit_o
);

  // Write packet open between AW and the last W beat
  logic lock_q;
  logic lock_d;
  // Round-robin pointer, low favors writes
  logic rr_q;
  logic rr_d;
  // Grant held over a stalled link cycle
  logic stall_q;
  logic sel_q;

  logic wr_req;
  logic rd_req;
  logic sel_rd;
  logic xfer;
  logic aw_xfer;
  logic w_last_xfer;
  logic ar_xfer;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  // Inside a write packet only W beats may compete
  assign wr_req = lock_q ? w_link.valid : aw_link.valid;
  assign rd_req = !lock_q && ar_link.valid;

  always_comb begin
    if (stall_q) begin
      sel_rd = sel_q;
    end else if (wr_req && rd_req) begin
      sel_rd = rr_q;
    end else begin
      sel_rd = rd_req;
    end
  end

  assign req_valid_o = sel_rd ? rd_req : wr_req;

  // Ready only reaches the granted sender
  assign ar_link.ready = sel_rd && req_ready_i;
  assign aw_link.ready = !sel_rd && !lock_q && req_ready_i;
  assign w_link.ready  = !sel_rd && lock_q && req_ready_i;

  ////////////////////////////////////////
  // Flit packing
  ////////////////////////////////////////

  always_comb begin
    if (sel_rd) begin
      req_flit_o.hdr     = ar_link.hdr;
      req_flit_o.payload = ar_link.payload;
    end else if (lock_q) begin
      req_flit_o.hdr     = w_link.hdr;
      req_flit_o.payload = w_link.payload;
    end else begin
      req_flit_o.hdr     = aw_link.hdr;
      req_flit_o.payload = aw_link.payload;
    end
  end

  ////////////////////////////////////////
  // Packet state
  ////////////////////////////////////////

  assign xfer        = req_valid_o && req_ready_i;
  assign aw_xfer     = xfer && !sel_rd && !lock_q;
  assign w_last_xfer = xfer && !sel_rd && lock_q && w_link.hdr.last;
  assign ar_xfer     = xfer && sel_rd;

  always_comb begin
    lock_d = lock_q;
    rr_d   = rr_q;
    if (aw_xfer) begin
      lock_d = 1'b1;
    end
    // Pointer only moves when a packet ends
    if (w_last_xfer) begin
      lock_d = 1'b0;
      rr_d   = 1'b1;
    end
    if (ar_xfer) begin
      rr_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q  <= 1'b0;
      rr_q    <= 1'b0;
      stall_q <= 1'b0;
      sel_q   <= 1'b0;
    end else begin
      lock_q  <= lock_d;
      rr_q    <= rr_d;
      stall_q <= req_valid_o && !req_ready_i;
      sel_q   <= sel_rd;
    end
  end

endmodule

/* hw/ni_rsp_unpacker.sv */
// NI response unpacker steering B and R flits onto the AXI response ports
`timescale 1ns/1ps

module ni_rsp_unpacker (
  ni_flit_if.receiver     rsp_link,
  // AXI write response
  output logic            b_valid_o,
  input  logic            b_ready_i,
  output ni_pkg::axi_id_t b_id_o,
  output ni_pkg::resp_t   b_resp_o,
  // AXI read data
  output logic            r_valid_o,
  input  logic            r_ready_i,
  output ni_pkg::axi_id_t r_id_o,
  output ni_pkg::data_t   r_data_o,
  output ni_pkg::resp_t   r_resp_o,
  output logic            r_last_o
);

  logic is_b;
  logic is_r;

  assign is_b = rsp_link.hdr.ch == ni_pkg::CH_B;
  assign is_r = rsp_link.hdr.ch == ni_pkg::CH_R;

  ////////////////////////////////////////
  // Channel decode
  ////////////////////////////////////////

  assign b_valid_o = rsp_link.valid && is_b;
  assign b_id_o    = rsp_link.payload.id;
  assign b_resp_o  = rsp_link.payload.resp;

  assign r_valid_o = rsp_link.valid && is_r;
  assign r_id_o    = rsp_link.payload.id;
  assign r_data_o  = rsp_link.payload.data;
  assign r_resp_o  = rsp_link.payload.resp;
  assign r_last_o  = rsp_link.payload.last;

  // Request channels have no sink here and get dropped
  always_comb begin
    if (is_b) begin
      rsp_link.ready = b_ready_i;
    end else if (is_r) begin
      rsp_link.ready = r_ready_i;
    end else begin
      rsp_link.ready = 1'b1;
    end
  end

endmodule

/* include/ni_config.svh */
// NI configuration macros for bus widths and the system address map
`ifndef NI_CONFIG_SVH
`define NI_CONFIG_SVH

// AXI manager port widths
`define NI_ADDR_W   32
`define NI_DATA_W   32
// One strobe bit per byte lane
`define NI_STRB_W   (`NI_DATA_W / 8)
`define NI_AXI_ID_W 4
`define NI_LEN_W    8

// Network node addressing
`define NI_NODE_W   4

// Address map, end addresses are exclusive
`define NI_NUM_RULES 4

`define NI_RULE_BASE_0 32'h0000_0000
`define NI_RULE_END_0  32'h1000_0000
`define NI_RULE_NODE_0 4'd1

`define NI_RULE_BASE_1 32'h1000_0000
`define NI_RULE_END_1  32'h2000_0000
`define NI_RULE_NODE_1 4'd2

`define NI_RULE_BASE_2 32'h2000_0000
`define NI_RULE_END_2  32'h3000_0000
`define NI_RULE_NODE_2 4'd3

`define NI_RULE_BASE_3 32'h3000_0000
`define NI_RULE_END_3  32'h4000_0000
`define NI_RULE_NODE_3 4'd4

// Destination for addresses outside every rule
`define NI_DEFAULT_NODE 4'd0

`endif

/* run.sh */
#!/usr/bin/env bash
# Compile and run the NI chimney testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f build.f \
  --top-module tb_ni_chimney \
  --Mdir obj_dir \
  -o sim_ni_chimney
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_ni_chimney 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Result: PASSED$"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

/* tb/ni_chimney_asserts.sv */
// NI chimney link protocol assertions, bound onto the top level
`timescale 1ns/1ps

module ni_chimney_asserts (
  input logic              clk_i,
  input logic              arst_n_i,
  input logic              req_valid_o,
  input logic              req_ready_i,
  input ni_pkg::req_flit_t req_flit_o,
  input logic              b_valid_o,
  input logic              r_valid_o
);

  // Set between an AW transfer and the W transfer that closes the packet
  logic in_pkt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_pkt_q <= 1'b0;
    end else if (req_valid_o && req_ready_i) begin
      if (req_flit_o.hdr.ch == ni_pkg::CH_AW) begin
        in_pkt_q <= 1'b1;
      end else if (req_flit_o.hdr.ch == ni_pkg::CH_W && req_flit_o.hdr.last) begin
        in_pkt_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Link properties
  ////////////////////////////////////////

  req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_flit_o))
    else $error("Request flit dropped or changed while the link was stalled");

  write_contiguous: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_pkt_q && req_valid_o && req_ready_i |-> req_flit_o.hdr.ch != ni_pkg::CH_AR)
    else $error("AR flit sent inside an open write packet");

  rsp_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(b_valid_o && r_valid_o))
    else $error("B and R valid raised in the same cycle");

endmodule

bind ni_chimney ni_chimney_asserts u_asserts (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .req_valid_o (req_valid_o),
  .req_ready_i (req_ready_i),
  .req_flit_o  (req_flit_o),
  .b_valid_o   (b_valid_o),
  .r_valid_o   (r_valid_o)
);

/* tb/tb_ni_chimney.sv */
// NI chimney directed testbench for request packing and response unpacking
`timescale 1ns/1ps
`include "ni_config.svh"

module tb_ni_chimney;

  localparam ni_pkg::node_id_t SRC_NODE = 4'd9;
  // The tests need under 100 cycles and 2000 leaves a wide margin
  localparam int MAX_CYCLES = 2000;

  logic clk_i, arst_n_i;
  ni_pkg::node_id_t node_id_i;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i, ar_valid_i, ar_ready_o;
  ni_pkg::addr_t aw_addr_i, ar_addr_i;
  ni_pkg::axi_id_t aw_id_i, ar_id_i, b_id_o, r_id_o;
  ni_pkg::len_t aw_len_i, ar_len_i;
  ni_pkg::data_t w_data_i, r_data_o;
  ni_pkg::strb_t w_strb_i;
  logic b_valid_o, b_ready_i, r_valid_o, r_ready_i, r_last_o;
  ni_pkg::resp_t b_resp_o, r_resp_o;
  logic req_valid_o, req_ready_i, rsp_valid_i, rsp_ready_o;
  ni_pkg::req_flit_t req_flit_o;
  ni_pkg::rsp_flit_t rsp_flit_i;

  integer seed;
  int value_errs, other_errs, cycle_cnt;
  ni_pkg::req_flit_t got_q[$];
  ni_pkg::req_flit_t exp_q[$];

  ni_chimney u_dut (.*);

  always #50 clk_i = ~clk_i;

  // Every flit that crosses the request link
  always @(posedge clk_i) begin
    if (arst_n_i && req_valid_o && req_ready_i) begin
      got_q.push_back(req_flit_o);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  // Four 256 MB windows from zero go to nodes 1 to 4
  function automatic ni_pkg::node_id_t expected_node(input ni_pkg::addr_t addr);
    if (addr < 32'h4000_0000) begin
      return addr[31:28] + 4'd1;
    end
    return `NI_DEFAULT_NODE;
  endfunction

  function automatic ni_pkg::req_flit_t ax_flit(input ni_pkg::axi_ch_e ch,
      input ni_pkg::addr_t addr, input ni_pkg::axi_id_t id, input ni_pkg::len_t len);
    ni_pkg::req_flit_t f;
    f = '0;
    f.hdr.dst_id = expected_node(addr);
    f.hdr.src_id = SRC_NODE;
    f.hdr.ch = ch;
    f.hdr.last = (ch == ni_pkg::CH_AR);
    f.payload.ax.addr = addr;
    f.payload.ax.id = id;
    f.payload.ax.len = len;
    return f;
  endfunction

  function automatic ni_pkg::req_flit_t w_flit(input ni_pkg::node_id_t dst,
      input ni_pkg::data_t data, input ni_pkg::strb_t strb, input logic last);
    ni_pkg::req_flit_t f;
    f = '0;
    f.hdr.dst_id = dst;
    f.hdr.src_id = SRC_NODE;
    f.hdr.ch = ni_pkg::CH_W;
    f.hdr.last = last;
    f.payload.w.data = data;
    f.payload.w.strb = strb;
    f.payload.w.last = last;
    return f;
  endfunction

  task automatic compare_flit(input string name, input ni_pkg::req_flit_t exp,
      input ni_pkg::req_flit_t got);
    assert (got === exp) else begin
      $display("FAIL %s: expected %h, actual %h", name, exp, got);
      value_errs++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
      input logic [31:0] got);
    assert (got === exp) else begin
      $display("FAIL %s: expected %h, actual %h", name, exp, got);
      value_errs++;
    end
  endtask

  function automatic logic count_ok(input string name, input int want);
    assert (got_q.size() == want) else begin
      $display("%s: request link carried %0d flits instead of %0d", name, got_q.size(), want);
      other_errs++;
    end
    return got_q.size() == want;
  endfunction

  // Whole packets in the expected order
  task automatic compare_queue(input string name);
    if (count_ok(name, exp_q.size())) begin
      for (int i = 0; i < exp_q.size(); i++) begin
        compare_flit(name, exp_q[i], got_q[i]);
      end
    end
  endtask

  ////////////////////////////////////////
  // AXI drivers
  ////////////////////////////////////////

  task automatic aw_handshake(input ni_pkg::addr_t addr, input ni_pkg::axi_id_t id,
      input ni_pkg::len_t len);
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_addr_i = addr;
    aw_id_i = id;
    aw_len_i = len;
    do @(posedge clk_i); while (!aw_ready_o);
    @(negedge clk_i);
    aw_valid_i = 1'b0;
  endtask

  task automatic w_handshake(input ni_pkg::data_t data, input ni_pkg::strb_t strb,
      input logic last);
    @(negedge clk_i);
    w_valid_i = 1'b1;
    w_data_i = data;
    w_strb_i = strb;
    w_last_i = last;
    do @(posedge clk_i); while (!w_ready_o);
    @(negedge clk_i);
    w_valid_i = 1'b0;
  endtask

  task automatic ar_handshake(input ni_pkg::addr_t addr, input ni_pkg::axi_id_t id,
      input ni_pkg::len_t len);
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_addr_i = addr;
    ar_id_i = id;
    ar_len_i = len;
    do @(posedge clk_i); while (!ar_ready_o);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  // Write packet of len+1 beats that also queues the expected flits
  task automatic write_packet(input ni_pkg::addr_t addr, input ni_pkg::len_t len);
    logic [31:0] rnd;
    ni_pkg::data_t data;
    rnd = $random(seed);
    exp_q.push_back(ax_flit(ni_pkg::CH_AW, addr, rnd[3:0], len));
    aw_handshake(addr, rnd[3:0], len);
    for (int i = 0; i <= int'(len); i++) begin
      rnd = $random(seed);
      data = $random(seed);
      exp_q.push_back(w_flit(expected_node(addr), data, rnd[3:0], i == int'(len)));
      w_handshake(data, rnd[3:0], i == int'(len));
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic read_requests();
    ni_pkg::addr_t addrs [5];
    logic [31:0] rnd;
    addrs = '{32'h0000_1000, 32'h1234_5670, 32'h2000_0040, 32'h3FFF_FFF0, 32'h8000_0000};
    for (int i = 0; i < 5; i++) begin
      got_q.delete();
      exp_q.delete();
      rnd = $random(seed);
      exp_q.push_back(ax_flit(ni_pkg::CH_AR, addrs[i], rnd[3:0], rnd[15:8]));
      ar_handshake(addrs[i], rnd[3:0], rnd[15:8]);
      compare_queue("read_requests");
    end
  endtask

  task automatic write_burst();
    got_q.delete();
    exp_q.delete();
    write_packet(32'h1000_0100, 8'd3);
    compare_queue("write_burst");
  endtask

  // AR is raised once the AW is in and stays pending over the open write packet
  task automatic mixed_traffic();
    ni_pkg::req_flit_t exp_rd;
    int rd_pos;
    int wr_pos;
    got_q.delete();
    exp_q.delete();
    exp_rd = ax_flit(ni_pkg::CH_AR, 32'h3000_0300, 4'd5, 8'd7);
    fork
      write_packet(32'h2000_0200, 8'd3);
      begin
        @(negedge clk_i);
        ar_handshake(32'h3000_0300, 4'd5, 8'd7);
      end
    join
    if (count_ok("mixed_traffic", 6)) begin
      rd_pos = (got_q[0].hdr.ch == ni_pkg::CH_AR) ? 0 : 5;
      wr_pos = (rd_pos == 0) ? 1 : 0;
      compare_flit("mixed_traffic", exp_rd, got_q[rd_pos]);
      for (int i = 0; i < 5; i++) begin
        compare_flit("mixed_traffic", exp_q[i], got_q[wr_pos + i]);
      end
    end
  endtask

  task automatic link_backpressure(input logic is_write);
    ni_pkg::req_flit_t exp;
    ni_pkg::addr_t addr;
    logic [31:0] rnd;
    int n;
    got_q.delete();
    rnd = $random(seed);
    n = 1 + rnd[2:0];
    addr = is_write ? 32'h0000_0400 : 32'h1000_0800;
    exp = ax_flit(is_write ? ni_pkg::CH_AW : ni_pkg::CH_AR, addr, rnd[7:4], 8'd0);
    @(negedge clk_i);
    req_ready_i = 1'b0;
    aw_valid_i = is_write;
    ar_valid_i = !is_write;
    aw_addr_i = addr;
    ar_addr_i = addr;
    aw_id_i = rnd[7:4];
    ar_id_i = rnd[7:4];
    aw_len_i = 8'd0;
    ar_len_i = 8'd0;
    repeat (n) begin
      @(posedge clk_i);
      check_value("link_backpressure valid", 32'(1), 32'(req_valid_o));
      compare_flit("link_backpressure", exp, req_flit_o);
      check_value("link_backpressure ready", 32'(0), 32'(is_write ? aw_ready_o : ar_ready_o));
    end
    @(negedge clk_i);
    req_ready_i = 1'b1;
    do @(posedge clk_i); while (!(is_write ? aw_ready_o : ar_ready_o));
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    ar_valid_i = 1'b0;
    // A lone beat closes the write packet
    if (is_write) begin
      w_handshake(32'hA5A5_0001, 4'hF, 1'b1);
    end
    if (count_ok("link_backpressure", is_write ? 2 : 1)) begin
      compare_flit("link_backpressure", exp, got_q[0]);
    end
  endtask

  task automatic response_unpacking();
    logic [31:0] rnd;
    ni_pkg::resp_t resp;
    int n;
    rnd = $random(seed);
    n = 1 + rnd[2:0];
    resp = rnd[4] ? ni_pkg::SLVERR : ni_pkg::OKAY;
    @(negedge clk_i);
    b_ready_i = 1'b0;
    rsp_flit_i = '0;
    rsp_flit_i.hdr.dst_id = SRC_NODE;
    rsp_flit_i.hdr.ch = ni_pkg::CH_B;
    rsp_flit_i.payload.id = rnd[11:8];
    rsp_flit_i.payload.resp = resp;
    rsp_valid_i = 1'b1;
    repeat (n) begin
      @(posedge clk_i);
      check_value("response_unpacking b_valid", 32'(1), 32'(b_valid_o));
      check_value("response_unpacking r_valid", 32'(0), 32'(r_valid_o));
      check_value("response_unpacking b_id", 32'(rnd[11:8]), 32'(b_id_o));
      check_value("response_unpacking b_resp", 32'(resp), 32'(b_resp_o));
      check_value("response_unpacking stalled ready", 32'(0), 32'(rsp_ready_o));
    end
    @(negedge clk_i);
    b_ready_i = 1'b1;
    @(posedge clk_i);
    check_value("response_unpacking released ready", 32'(1), 32'(rsp_ready_o));
    // Two read beats where the second one closes the burst
    for (int i = 0; i < 2; i++) begin
      rnd = $random(seed);
      resp = rnd[4] ? ni_pkg::SLVERR : ni_pkg::OKAY;
      @(negedge clk_i);
      // R beats are taken through r_ready_i alone
      b_ready_i = 1'b0;
      rsp_flit_i.hdr.ch = ni_pkg::CH_R;
      rsp_flit_i.payload.id = rnd[11:8];
      rsp_flit_i.payload.resp = resp;
      rsp_flit_i.payload.data = $random(seed);
      rsp_flit_i.payload.last = (i == 1);
      @(posedge clk_i);
      check_value("response_unpacking r_valid", 32'(1), 32'(r_valid_o));
      check_value("response_unpacking b_valid", 32'(0), 32'(b_valid_o));
      check_value("response_unpacking r_id", 32'(rnd[11:8]), 32'(r_id_o));
      check_value("response_unpacking r_data", rsp_flit_i.payload.data, r_data_o);
      check_value("response_unpacking r_resp", 32'(resp), 32'(r_resp_o));
      check_value("response_unpacking r_last", 32'(i == 1), 32'(r_last_o));
      check_value("response_unpacking r ready", 32'(1), 32'(rsp_ready_o));
    end
    @(negedge clk_i);
    rsp_valid_i = 1'b0;
    b_ready_i = 1'b1;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    seed = 61387;
    value_errs = 0;
    other_errs = 0;
    cycle_cnt = 0;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    node_id_i = SRC_NODE;
    aw_valid_i = 1'b0;
    aw_addr_i = '0;
    aw_id_i = '0;
    aw_len_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_last_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i = '0;
    ar_id_i = '0;
    ar_len_i = '0;
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    req_ready_i = 1'b1;
    rsp_valid_i = 1'b0;
    rsp_flit_i = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    read_requests();
    write_burst();
    mixed_traffic();
    link_backpressure(1'b0);
    link_backpressure(1'b1);
    response_unpacking();

    repeat (2) @(negedge clk_i);
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
